// ==== verilog/soc_pkg.sv ====
package soc_pkg;

	// Address map, bits 31..28 of the bus address
	typedef enum logic [3:0] {
		region_psram = 4'd0,
		region_uart  = 4'd1,
		region_ctrl  = 4'd2
	} region_e;

	localparam logic [31:0] unmapped_rdata = 32'hdeadbeef;

	// Quad-SPI PSRAM commands
	localparam logic [7:0] psram_cmd_read  = 8'heb; // Quad fast read
	localparam logic [7:0] psram_cmd_write = 8'h38; // Quad write

	localparam int psram_addr_bits = 24;
	localparam logic [3:0] psram_wait_cycles  = 4'd6;
	localparam logic [3:0] psram_cmd_nibbles  = 4'd2;
	localparam logic [3:0] psram_addr_nibbles = 4'd6;
	localparam logic [3:0] psram_data_nibbles = 4'd8;

	localparam logic [31:0] uart_div_reset = 32'd415; // 115200 baud at 48 MHz

	typedef enum logic [2:0] {
		qpi_idle,
		qpi_cmd,
		qpi_addr,
		qpi_wait,
		qpi_data,
		qpi_done
	} qpi_state_e;

	typedef enum logic [1:0] {
		tx_idle,
		tx_start,
		tx_bits,
		tx_stop
	} uart_tx_state_e;

endpackage

// ==== verilog/periph_bus_if.sv ====
interface periph_bus_if;
	logic        sel;
	logic [21:0] index; // Word index, address bits 23..2
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic [31:0] rdata;
	logic        ready;

	modport master (
		output sel, index, wdata, wstrb,
		input  rdata, ready
	);

	modport slave (
		input  sel, index, wdata, wstrb,
		output rdata, ready
	);

endinterface

// ==== verilog/bus_decode.sv ====
module bus_decode (
	input  logic        mem_valid,
	input  logic [31:0] mem_addr,
	input  logic [31:0] mem_wdata,
	input  logic [3:0]  mem_wstrb,
	output logic [31:0] mem_rdata,
	output logic        mem_ready,
	periph_bus_if.master psram,
	periph_bus_if.master uart,
	periph_bus_if.master ctrl
);
	import soc_pkg::*;

	region_e region;

	assign region = region_e'(mem_addr[31:28]);

	assign psram.index = mem_addr[23:2];
	assign psram.wdata = mem_wdata;
	assign psram.wstrb = mem_wstrb;

	assign uart.index = mem_addr[23:2];
	assign uart.wdata = mem_wdata;
	assign uart.wstrb = mem_wstrb;

	assign ctrl.index = mem_addr[23:2];
	assign ctrl.wdata = mem_wdata;
	assign ctrl.wstrb = mem_wstrb;

	always_comb begin
		psram.sel = 1'b0;
		uart.sel = 1'b0;
		ctrl.sel = 1'b0;
		case (region)
			region_psram: begin
				psram.sel = mem_valid;
				mem_rdata = psram.rdata;
				mem_ready = psram.ready;
			end
			region_uart: begin
				uart.sel = mem_valid;
				mem_rdata = uart.rdata;
				mem_ready = uart.ready;
			end
			region_ctrl: begin
				ctrl.sel = mem_valid;
				mem_rdata = ctrl.rdata;
				mem_ready = ctrl.ready;
			end
			default: begin
				// Unmapped: answer at once so the CPU never hangs
				mem_rdata = unmapped_rdata;
				mem_ready = mem_valid;
			end
		endcase
	end

endmodule

// ==== verilog/uart_regs.sv ====
module uart_regs (
	input  logic clk48m,
	input  logic resetn,
	periph_bus_if.slave bus,
	output logic uart_tx,
	input  logic uart_rx
);
	import soc_pkg::*;

	logic [31:0]    div;
	uart_tx_state_e tx_state;
	logic [31:0]    tx_cnt;
	logic [2:0]     tx_bit;
	logic [7:0]     tx_shift;
	logic [1:0]     rx_sync;
	logic           rx_in;
	logic           rx_busy;
	logic [31:0]    rx_cnt;
	logic [31:0]    rx_target;
	logic [3:0]     rx_bit;
	logic [7:0]     rx_shift;
	logic [7:0]     rx_byte;
	logic           rx_valid;
	logic           div_sel;
	logic           dat_sel;
	logic           dat_we;
	logic           dat_re;
	logic           tx_busy;

	assign div_sel = bus.sel && bus.index[0];
	assign dat_sel = bus.sel && !bus.index[0];
	assign tx_busy = (tx_state != tx_idle);
	assign dat_we = dat_sel && bus.wstrb[0] && !tx_busy;
	assign dat_re = dat_sel && (bus.wstrb == 4'b0000);
	assign bus.ready = div_sel || (dat_sel && !(bus.wstrb[0] && tx_busy)); // Stall while sending
	assign bus.rdata = bus.index[0] ? div : (rx_valid ? {24'h0, rx_byte} : 32'hffff_ffff);

	always_ff @(posedge clk48m) begin
		if (!resetn) begin
			div <= uart_div_reset;
		end else if (div_sel) begin
			for (int i = 0; i < 4; i++) begin
				if (bus.wstrb[i]) begin
					div[8*i +: 8] <= bus.wdata[8*i +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk48m) begin
		if (!resetn) begin
			tx_state <= tx_idle;
			uart_tx <= 1'b1;
			tx_cnt <= '0;
			tx_bit <= '0;
		end else begin
			case (tx_state)
				tx_idle: begin
					if (dat_we) begin
						tx_shift <= bus.wdata[7:0];
						uart_tx <= 1'b0; // Start bit
						tx_cnt <= '0;
						tx_state <= tx_start;
					end
				end
				tx_start: begin
					if (tx_cnt == div) begin
						tx_cnt <= '0;
						tx_bit <= '0;
						uart_tx <= tx_shift[0];
						tx_shift <= tx_shift >> 1;
						tx_state <= tx_bits;
					end else begin
						tx_cnt <= tx_cnt + 32'd1;
					end
				end
				tx_bits: begin
					if (tx_cnt == div) begin
						tx_cnt <= '0;
						if (tx_bit == 3'd7) begin
							uart_tx <= 1'b1; // Stop bit
							tx_state <= tx_stop;
						end else begin
							uart_tx <= tx_shift[0];
							tx_shift <= tx_shift >> 1;
							tx_bit <= tx_bit + 3'd1;
						end
					end else begin
						tx_cnt <= tx_cnt + 32'd1;
					end
				end
				tx_stop: begin
					if (tx_cnt == div) begin
						tx_state <= tx_idle;
					end else begin
						tx_cnt <= tx_cnt + 32'd1;
					end
				end
				default: tx_state <= tx_idle;
			endcase
		end
	end

	assign rx_in = rx_sync[1];
	assign rx_target = (rx_bit == 4'd0) ? {1'b0, div[31:1]} : div; // Half bit to mid start

	always_ff @(posedge clk48m) begin
		if (!resetn) begin
			rx_sync <= 2'b11;
			rx_busy <= 1'b0;
			rx_valid <= 1'b0;
			rx_cnt <= '0;
			rx_bit <= '0;
		end else begin
			rx_sync <= {rx_sync[0], uart_rx};
			if (dat_re) begin
				rx_valid <= 1'b0;
			end
			if (!rx_busy) begin
				if (!rx_in) begin
					rx_busy <= 1'b1;
					rx_cnt <= '0;
					rx_bit <= '0;
				end
			end else if (rx_cnt == rx_target) begin
				rx_cnt <= '0;
				if (rx_bit == 4'd0) begin
					if (rx_in) begin
						rx_busy <= 1'b0; // Glitch, not a start bit
					end else begin
						rx_bit <= 4'd1;
					end
				end else if (rx_bit == 4'd9) begin
					rx_busy <= 1'b0;
					if (rx_in) begin
						rx_byte <= rx_shift;
						rx_valid <= 1'b1;
					end
				end else begin
					rx_shift <= {rx_in, rx_shift[7:1]};
					rx_bit <= rx_bit + 4'd1;
				end
			end else begin
				rx_cnt <= rx_cnt + 32'd1;
			end
		end
	end

endmodule

// ==== verilog/qpi_psram.sv ====
module qpi_psram (
	input  logic       clk48m,
	input  logic       resetn,
	periph_bus_if.slave bus,
	output logic       psram_sclk,
	output logic       psram_nce,
	output logic [3:0] psram_sout,
	input  logic [3:0] psram_sin,
	output logic       psram_oe
);
	import soc_pkg::*;

	qpi_state_e                 state;
	logic [31:0]                osr;
	logic [31:0]                wbuf;
	logic [31:0]                ibuf;
	logic [3:0]                 nib_cnt;
	logic                       is_wr;
	logic                       idle_hold;
	logic [psram_addr_bits-1:0] byte_addr;
	logic                       wr_req;
	logic                       falling;

	assign byte_addr = {bus.index, 2'b00};
	assign wr_req = (bus.wstrb != 4'b0000);
	assign falling = psram_sclk; // Next toggle takes sclk low
	assign psram_sout = osr[31:28];
	assign bus.ready = (state == qpi_done);
	assign bus.rdata = ibuf;

	always_ff @(posedge clk48m) begin
		if (!resetn) begin
			state <= qpi_idle;
			psram_sclk <= 1'b0;
			psram_nce <= 1'b1;
			psram_oe <= 1'b0;
			osr <= '0;
			nib_cnt <= '0;
			is_wr <= 1'b0;
			idle_hold <= 1'b0;
		end else begin
			if (state != qpi_idle && state != qpi_done) begin
				psram_sclk <= !psram_sclk;
			end
			case (state)
				qpi_idle: begin
					idle_hold <= 1'b0;
					if (bus.sel && !idle_hold) begin
						if (wr_req && bus.wstrb != 4'b1111) begin
							state <= qpi_done; // Partial writes are dropped
						end else begin
							psram_nce <= 1'b0;
							psram_oe <= 1'b1;
							is_wr <= wr_req;
							nib_cnt <= '0;
							osr <= {wr_req ? psram_cmd_write : psram_cmd_read, byte_addr};
							wbuf <= bus.wdata;
							state <= qpi_cmd;
						end
					end
				end
				qpi_cmd: begin
					if (falling) begin
						osr <= osr << 4;
						nib_cnt <= nib_cnt + 4'd1;
						if (nib_cnt == psram_cmd_nibbles - 4'd1) begin
							nib_cnt <= '0;
							state <= qpi_addr;
						end
					end
				end
				qpi_addr: begin
					if (falling) begin
						osr <= osr << 4;
						nib_cnt <= nib_cnt + 4'd1;
						if (nib_cnt == psram_addr_nibbles - 4'd1) begin
							nib_cnt <= '0;
							if (is_wr) begin
								osr <= wbuf;
								state <= qpi_data;
							end else begin
								psram_oe <= 1'b0; // Hand the bus to the chip
								state <= qpi_wait;
							end
						end
					end
				end
				qpi_wait: begin
					if (falling) begin
						nib_cnt <= nib_cnt + 4'd1;
						if (nib_cnt == psram_wait_cycles - 4'd1) begin
							nib_cnt <= '0;
							state <= qpi_data;
						end
					end
				end
				qpi_data: begin
					if (!falling && !is_wr) begin
						ibuf <= {ibuf[27:0], psram_sin};
					end
					if (falling) begin
						osr <= osr << 4;
						nib_cnt <= nib_cnt + 4'd1;
						if (nib_cnt == psram_data_nibbles - 4'd1) begin
							psram_nce <= 1'b1;
							psram_oe <= 1'b0;
							state <= qpi_done;
						end
					end
				end
				qpi_done: begin
					idle_hold <= 1'b1; // Master still holds sel this cycle
					state <= qpi_idle;
				end
				default: state <= qpi_idle;
			endcase
		end
	end

endmodule

// ==== verilog/ctrl_regs.sv ====
module ctrl_regs (
	input  logic       clk48m,
	input  logic       resetn,
	periph_bus_if.slave bus,
	output logic [5:0] led,
	input  logic       qpi_sclk,
	input  logic       qpi_nce,
	input  logic [3:0] qpi_sout,
	input  logic       qpi_oe,
	output logic       psram_sclk,
	output logic       psram_nce,
	output logic [3:0] psram_sout,
	output logic       psram_oe
);

	logic [7:0] ovr;
	logic       ovr_en;

	always_ff @(posedge clk48m) begin
		if (!resetn) begin
			led <= '0;
			ovr <= '0;
		end else if (bus.sel && bus.wstrb[0]) begin
			if (bus.index == 22'd0) begin
				led <= bus.wdata[5:0];
			end else if (bus.index == 22'd1) begin
				ovr <= bus.wdata[7:0];
			end
		end
	end

	assign bus.ready = bus.sel;
	assign bus.rdata = (bus.index == 22'd0) ? {26'h0, led} :
		(bus.index == 22'd1) ? {24'h0, ovr} : 32'h0;

	// Bit 7 hands the PSRAM pins to software
	assign ovr_en = ovr[7];
	assign psram_oe = ovr_en ? ovr[6] : qpi_oe;
	assign psram_sclk = ovr_en ? ovr[5] : qpi_sclk;
	assign psram_nce = ovr_en ? ovr[4] : qpi_nce;
	assign psram_sout = ovr_en ? ovr[3:0] : qpi_sout;

endmodule

// ==== verilog/soc_periph.sv ====
module soc_periph (
	input  logic        clk48m,
	input  logic        resetn,
	input  logic        mem_valid,
	input  logic [31:0] mem_addr,
	input  logic [31:0] mem_wdata,
	input  logic [3:0]  mem_wstrb,
	output logic [31:0] mem_rdata,
	output logic        mem_ready,
	output logic [5:0]  led,
	output logic        uart_tx,
	input  logic        uart_rx,
	output logic        psram_sclk,
	output logic        psram_nce,
	output logic [3:0]  psram_sout,
	input  logic [3:0]  psram_sin,
	output logic        psram_oe
);

	periph_bus_if psram_bus ();
	periph_bus_if uart_bus ();
	periph_bus_if ctrl_bus ();

	logic       qpi_sclk; // Controller pins before the override mux
	logic       qpi_nce;
	logic [3:0] qpi_sout;
	logic       qpi_oe;

	bus_decode u_decode (
		.mem_valid (mem_valid),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_wstrb (mem_wstrb),
		.mem_rdata (mem_rdata),
		.mem_ready (mem_ready),
		.psram     (psram_bus.master),
		.uart      (uart_bus.master),
		.ctrl      (ctrl_bus.master)
	);

	uart_regs u_uart (
		.clk48m  (clk48m),
		.resetn  (resetn),
		.bus     (uart_bus.slave),
		.uart_tx (uart_tx),
		.uart_rx (uart_rx)
	);

	qpi_psram u_psram (
		.clk48m     (clk48m),
		.resetn     (resetn),
		.bus        (psram_bus.slave),
		.psram_sclk (qpi_sclk),
		.psram_nce  (qpi_nce),
		.psram_sout (qpi_sout),
		.psram_sin  (psram_sin),
		.psram_oe   (qpi_oe)
	);

	ctrl_regs u_ctrl (
		.clk48m     (clk48m),
		.resetn     (resetn),
		.bus        (ctrl_bus.slave),
		.led        (led),
		.qpi_sclk   (qpi_sclk),
		.qpi_nce    (qpi_nce),
		.qpi_sout   (qpi_sout),
		.qpi_oe     (qpi_oe),
		.psram_sclk (psram_sclk),
		.psram_nce  (psram_nce),
		.psram_sout (psram_sout),
		.psram_oe   (psram_oe)
	);

endmodule

// ==== testbench/soc_props.sv ====
module soc_props (
	input logic                clk48m,
	input logic                resetn,
	input logic                sel,
	input logic                ready,
	input soc_pkg::qpi_state_e state,
	input logic                nce,
	input logic                oe
);
	timeunit 1ns;
	timeprecision 1ps;
	import soc_pkg::*;

	int fail_count = 0;

	ready_needs_sel: assert property (@(posedge clk48m) disable iff (!resetn) ready |-> sel)
	else begin
		fail_count++;
		$error("ready high without sel");
	end

	nce_high_in_idle: assert property (@(posedge clk48m) disable iff (!resetn)
		(state == qpi_idle) |-> nce)
	else begin
		fail_count++;
		$error("psram nce low while the controller is idle");
	end

	oe_low_in_wait: assert property (@(posedge clk48m) disable iff (!resetn)
		(state == qpi_wait) |-> !oe)
	else begin
		fail_count++;
		$error("psram oe driven during the wait phase");
	end

endmodule

// ==== testbench/psram_model.sv ====
module psram_model (
	input  logic       sclk,
	input  logic       nce,
	input  logic [3:0] sout,
	input  logic       oe,
	output logic [3:0] sin
);
	timeunit 1ns;
	timeprecision 1ps;
	import soc_pkg::*;

	logic [7:0]  mem [0:4095]; // Only the low 4 KB of the part
	logic [7:0]  cmd;
	logic [23:0] addr;
	logic [31:0] word;
	int          edges; // Rising sclk edges since nce fell

	function automatic logic [31:0] load_word(input logic [11:0] a);
		return {mem[a + 12'd3], mem[a + 12'd2], mem[a + 12'd1], mem[a]};
	endfunction

	task automatic store_word(input logic [11:0] a, input logic [31:0] w);
		for (int i = 0; i < 4; i++) begin
			mem[a + 12'(i)] = w[8*i +: 8]; // Little endian
		end
	endtask

	initial begin
		sin = 4'h0;
		edges = 0;
		for (int i = 0; i < 4096; i++) begin
			mem[i] = i[7:0] ^ {i[11:8], i[11:8]};
		end
	end

	always @(negedge nce) begin
		edges = 0;
	end

	always @(posedge sclk) begin
		if (!nce) begin
			edges = edges + 1;
			if (edges <= 2) begin
				cmd = {cmd[3:0], sout};
			end else if (edges <= 8) begin
				addr = {addr[19:0], sout};
			end else if (cmd == psram_cmd_write && edges <= 16) begin
				word = {word[27:0], sout};
				if (edges == 16) begin
					store_word(addr[11:0], word);
				end
			end
		end
	end

	// Data goes out after the sixth wait clock, one nibble per falling edge
	always @(negedge sclk) begin
		if (!nce && !oe && cmd == psram_cmd_read && edges >= 14 && edges <= 21) begin
			if (edges == 14) begin
				word = load_word(addr[11:0]);
			end
			sin = word[31:28];
			word = word << 4;
		end
	end

endmodule

// ==== testbench/tb_soc.sv ====
module tb_soc;
	timeunit 1ns;
	timeprecision 1ps;
	import soc_pkg::*;

	localparam int bus_timeout = 2000; // Cycles for a stalled UART write
	localparam int poll_limit = 1000;
	localparam logic [31:0] uart_data_addr = 32'h1000_0000;
	localparam logic [31:0] uart_div_addr = 32'h1000_0004;
	localparam logic [31:0] led_addr = 32'h2000_0000;
	localparam logic [31:0] ovr_addr = 32'h2000_0004;

	typedef enum logic [1:0] {op_write, op_read, op_poll} op_e;

	typedef struct packed {
		op_e         op;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic [31:0] exp_rdata;
	} row_t;

	logic        clk48m;
	logic        resetn;
	logic        mem_valid;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [3:0]  mem_wstrb;
	logic [31:0] mem_rdata;
	logic        mem_ready;
	logic [5:0]  led;
	logic        uart_tx;
	logic        uart_rx;
	logic        psram_sclk;
	logic        psram_nce;
	logic [3:0]  psram_sout;
	logic [3:0]  psram_sin;
	logic        psram_oe;

	row_t        rows[$];
	logic [31:0] lcg_state = 32'hff1c;
	int          checks = 0;
	int          errors = 0;
	int          timeouts = 0;

	soc_periph uut (
		.clk48m     (clk48m),
		.resetn     (resetn),
		.mem_valid  (mem_valid),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_wstrb  (mem_wstrb),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready),
		.led        (led),
		.uart_tx    (uart_tx),
		.uart_rx    (uart_rx),
		.psram_sclk (psram_sclk),
		.psram_nce  (psram_nce),
		.psram_sout (psram_sout),
		.psram_sin  (psram_sin),
		.psram_oe   (psram_oe)
	);

	psram_model u_mem (
		.sclk (psram_sclk),
		.nce  (psram_nce),
		.sout (psram_sout),
		.oe   (psram_oe),
		.sin  (psram_sin)
	);

	bind qpi_psram soc_props u_props (
		.clk48m (clk48m),
		.resetn (resetn),
		.sel    (bus.sel),
		.ready  (bus.ready),
		.state  (state),
		.nce    (psram_nce),
		.oe     (psram_oe)
	);

	assign uart_rx = uart_tx; // Loopback

	initial begin
		clk48m = 1'b0;
		forever #5 clk48m = ~clk48m;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_word(input logic [31:0] addr, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED mem_rdata at %h: got %h, expected %h", addr, got, exp);
		end
	endtask

	task automatic check_led(input logic [5:0] got, input logic [5:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED led: got %h, expected %h", got, exp);
		end
	endtask

	task automatic check_pins(input string name, input logic [6:0] got, input logic [6:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] wstrb, output logic [31:0] rdata);
		int cycles;
		cycles = 0;
		@(negedge clk48m);
		mem_valid = 1'b1;
		mem_addr = addr;
		mem_wdata = wdata;
		mem_wstrb = wstrb;
		@(posedge clk48m);
		while (!mem_ready && cycles < bus_timeout) begin
			@(posedge clk48m);
			cycles++;
		end
		rdata = mem_rdata;
		if (!mem_ready) begin
			timeouts++;
			$display("No mem_ready for address %h within %0d cycles", addr, bus_timeout);
		end
		@(negedge clk48m);
		mem_valid = 1'b0;
		mem_wstrb = 4'b0000;
	endtask

	// Reads UART data until a byte shows up
	task automatic poll_uart(output logic [31:0] rdata, output logic arrived);
		int polls;
		polls = 0;
		rdata = 32'hffff_ffff;
		while (rdata === 32'hffff_ffff && polls < poll_limit) begin
			bus_access(uart_data_addr, 32'h0, 4'b0000, rdata);
			polls++;
		end
		arrived = (rdata !== 32'hffff_ffff);
		if (!arrived) begin
			timeouts++;
			$display("No UART byte received after %0d polls", polls);
		end
	endtask

	task automatic add_row(input op_e op, input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] wstrb, input logic [31:0] exp_rdata);
		row_t r;
		r.op = op;
		r.addr = addr;
		r.wdata = wdata;
		r.wstrb = wstrb;
		r.exp_rdata = exp_rdata;
		rows.push_back(r);
	endtask

	task automatic build_table();
		logic [31:0] psram_addr [4];
		logic [31:0] psram_data [4];
		psram_addr[0] = 32'h0000_0010;
		psram_addr[1] = 32'h0000_0124;
		psram_addr[2] = 32'h0000_0238;
		psram_addr[3] = 32'h0000_034c;
		add_row(op_read, 32'h4000_0000, 32'h0, 4'b0000, 32'hdeadbeef); // Region 4
		add_row(op_write, uart_div_addr, 32'h1234_5678, 4'b1111, 32'h0);
		add_row(op_write, uart_div_addr, 32'haabb_ccdd, 4'b0101, 32'h0);
		add_row(op_read, uart_div_addr, 32'h0, 4'b0000, 32'h12bb_56dd);
		add_row(op_write, uart_div_addr, 32'd15, 4'b1111, 32'h0); // Short frames
		add_row(op_read, uart_data_addr, 32'h0, 4'b0000, 32'hffff_ffff);
		add_row(op_write, uart_data_addr, 32'h0000_005a, 4'b0001, 32'h0);
		add_row(op_write, uart_data_addr, 32'h0000_00c3, 4'b0001, 32'h0); // Stalls
		add_row(op_poll, uart_data_addr, 32'h0, 4'b0000, 32'h0000_005a);
		add_row(op_poll, uart_data_addr, 32'h0, 4'b0000, 32'h0000_00c3);
		add_row(op_read, uart_data_addr, 32'h0, 4'b0000, 32'hffff_ffff);
		for (int i = 0; i < 4; i++) begin
			psram_data[i] = lcg_next();
			add_row(op_write, psram_addr[i], psram_data[i], 4'b1111, 32'h0);
		end
		for (int i = 0; i < 4; i++) begin
			add_row(op_read, psram_addr[i], 32'h0, 4'b0000, psram_data[i]);
		end
		add_row(op_write, psram_addr[0], ~psram_data[0], 4'b0011, 32'h0); // Dropped
		add_row(op_read, psram_addr[0], 32'h0, 4'b0000, psram_data[0]);
		add_row(op_write, led_addr, 32'h0000_002a, 4'b0001, 32'h0);
		add_row(op_read, led_addr, 32'h0, 4'b0000, 32'h0000_002a);
	endtask

	task automatic apply_row(input row_t r);
		logic [31:0] rdata;
		logic        arrived;
		case (r.op)
			op_write: bus_access(r.addr, r.wdata, r.wstrb, rdata);
			op_read: begin
				bus_access(r.addr, 32'h0, 4'b0000, rdata);
				check_word(r.addr, rdata, r.exp_rdata);
			end
			op_poll: begin
				poll_uart(rdata, arrived);
				if (arrived) begin
					check_word(r.addr, rdata, r.exp_rdata);
				end
			end
			default: ;
		endcase
	endtask

	initial begin
		logic [31:0] rdata;
		resetn = 1'b0;
		mem_valid = 1'b0;
		mem_addr = 32'h0;
		mem_wdata = 32'h0;
		mem_wstrb = 4'b0000;
		build_table();
		repeat (2) @(posedge clk48m);
		@(negedge clk48m);
		resetn = 1'b1;

		// Idle levels after reset
		check_pins("psram oe/sclk/nce after reset", {4'h0, psram_oe, psram_sclk, psram_nce},
			7'h01);
		check_pins("uart_tx after reset", {6'h0, uart_tx}, 7'h01);

		for (int i = 0; i < rows.size(); i++) begin
			apply_row(rows[i]);
		end
		check_led(led, 6'h2a);

		// Override 8'he5 puts oe and sclk high, nce low and 4'b0101 on sout
		bus_access(ovr_addr, 32'h0000_00e5, 4'b0001, rdata);
		check_pins("psram pins", {psram_oe, psram_sclk, psram_nce, psram_sout}, 7'h65);
		bus_access(ovr_addr, 32'h0, 4'b0000, rdata);
		check_word(ovr_addr, rdata, 32'h0000_00e5);
		bus_access(ovr_addr, 32'h0, 4'b0001, rdata);
		check_pins("psram oe/sclk/nce", {4'h0, psram_oe, psram_sclk, psram_nce}, 7'h01);

		$display("%0d checks, %0d mismatches, %0d timeouts, %0d assertion failures",
			checks, errors, timeouts, uut.u_psram.u_props.fail_count);
		if (errors == 0 && timeouts == 0 && uut.u_psram.u_props.fail_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
verilog/soc_pkg.sv
verilog/periph_bus_if.sv
verilog/bus_decode.sv
verilog/uart_regs.sv
verilog/qpi_psram.sv
verilog/ctrl_regs.sv
verilog/soc_periph.sv
testbench/soc_props.sv
testbench/psram_model.sv
testbench/tb_soc.sv

// ==== Bender.yml ====
package:
  name: soc_periph

sources:
  - verilog/soc_pkg.sv
  - verilog/periph_bus_if.sv
  - verilog/bus_decode.sv
  - verilog/uart_regs.sv
  - verilog/qpi_psram.sv
  - verilog/ctrl_regs.sv
  - verilog/soc_periph.sv
  - target: test
    files:
      - testbench/soc_props.sv
      - testbench/psram_model.sv
      - testbench/tb_soc.sv
